// File: project.f
source/fp_word_pkg.sv
source/fpadd_ctrl_pkg.sv
source/fpadd_special.sv
source/fpadd_align.sv
source/fpadd_renorm.sv
source/fpadd_round.sv
source/fpadd_top.sv
bench/fpadd_clkgen.sv
bench/fpadd_checker.sv
bench/fpadd_tb.sv

// File: bench/fpadd_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fpadd_tb;

  logic clk;
  logic rst;
  logic in_valid;
  fpadd_ctrl_pkg::fpadd_req_t req;
  logic out_valid;
  fp_word_pkg::fp_word_t res;
  fpadd_ctrl_pkg::fpadd_flags_t flags;
  int checks;
  int errors;
  int pending;
  int checks_at_start;
  int errors_at_start;
  integer seed = 73;

  fpadd_clkgen #(.period(4)) clock_i (
    .clk(clk)
  );

  fpadd_top #(.sticky_w(3)) fpadd_top_i (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .req(req),
    .out_valid(out_valid),
    .res(res),
    .flags(flags)
  );

  fpadd_checker checker_i (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .req(req),
    .out_valid(out_valid),
    .res(res),
    .flags(flags),
    .checks(checks),
    .errors(errors),
    .pending(pending)
  );

  function automatic int pick(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fffffff;
    return lo + r % (hi - lo + 1);
  endfunction

  // exponent msb sits above the sign
  function automatic logic [32:0] make_word(input logic s, input logic [8:0] e,
                                            input logic [22:0] f);
    return {e[8], s, e[7:0], f};
  endfunction

  task automatic send(input logic [32:0] a, input logic [32:0] b, input logic [2:0] op,
                      input logic [1:0] rm);
    @(negedge clk);
    in_valid = 1'b1;
    req.a.raw = a;
    req.b.raw = b;
    req.op = fpadd_ctrl_pkg::fpadd_op_e'(op);
    req.rmode = fpadd_ctrl_pkg::round_mode_e'(rm);
  endtask

  task automatic idle();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic send_arith(input int e_lo, input int e_hi, input int max_diff,
                            input bit opposite, input bit close_frac);
    int ea;
    int eb;
    int op;
    logic sa;
    logic sb;
    logic [22:0] fa;
    logic [22:0] fb;
    ea = pick(e_lo, e_hi);
    eb = ea + pick(-max_diff, max_diff);
    if (eb < e_lo) eb = e_lo;
    if (eb > e_hi) eb = e_hi;
    fa = $random(seed);
    if (close_frac) fb = fa ^ pick(0, 15);
    else fb = $random(seed);
    op = pick(0, 2);
    sa = $random(seed);
    // pick sign of b so the effective signs agree or differ as asked
    sb = sa ^ (op == 2) ^ (op == 1) ^ opposite;
    send(make_word(sa, ea, fa), make_word(sb, eb, fb), op, pick(0, 3));
  endtask

  task automatic send_special();
    int kind;
    logic [32:0] a;
    logic [32:0] b;
    kind = pick(0, 5);
    a = make_word($random(seed), pick(1, 509), $random(seed));
    b = make_word($random(seed), pick(1, 509), $random(seed));
    case (kind)
      0: a = make_word($random(seed), 9'h1ff, $random(seed));
      1: b = make_word($random(seed), 9'h1ff, $random(seed));
      2: begin
        a = make_word($random(seed), 9'h1fe, $random(seed));
        b = make_word($random(seed), 9'h1fe, $random(seed));
      end
      3: a = make_word($random(seed), 9'h1fe, $random(seed));
      4: b = make_word($random(seed), 9'h1fe, $random(seed));
      default: begin
        if (pick(0, 2) != 1) a = make_word($random(seed), 9'h0, $random(seed));
        if (pick(0, 2) != 0) b = make_word($random(seed), 9'h0, $random(seed));
      end
    endcase
    send(a, b, pick(0, 2), pick(0, 3));
  endtask

  task automatic send_raw();
    send({$random(seed), $random(seed)}, {$random(seed), $random(seed)}, pick(3, 7),
         pick(0, 3));
  endtask

  task automatic finish_test(input string name);
    int waited;
    idle();
    waited = 0;
    while (pending != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (pending != 0) begin
      $display("%s: %0d results never arrived", name, pending);
      $display("TESTS FAILED");
      $finish;
    end else begin
      $display("%s: %0d checks, %0d errors", name, checks - checks_at_start,
               errors - errors_at_start);
      checks_at_start = checks;
      errors_at_start = errors;
    end
  endtask

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    req = '0;
    checks_at_start = 0;
    errors_at_start = 0;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < 300; i++) begin
      send_arith(1, 480, 30, 1'b0, 1'b0);
      if (pick(0, 2) == 0) idle();
    end
    finish_test("random add same sign");

    for (int rm = 0; rm < 4; rm++) begin
      send(make_word(1'b0, 9'd200, 23'h123456), make_word(1'b0, 9'd200, 23'h123456), 3'd1, rm);
      idle();
    end
    for (int i = 0; i < 200; i++) begin
      send_arith(1, 509, 1, 1'b1, 1'b1);
      if (pick(0, 2) == 0) idle();
    end
    finish_test("cancellation");

    for (int i = 0; i < 200; i++) begin
      send_special();
      if (pick(0, 2) == 0) idle();
    end
    finish_test("special cases");

    send(make_word(1'b0, 9'h1fd, 23'h7fffff), make_word(1'b0, 9'h1fd, 23'h7fffff), 3'd0, 2'd0);
    for (int i = 0; i < 100; i++) begin
      send_arith(490, 509, 3, 1'b0, 1'b0);
      send_arith(1, 3, 1, 1'b1, 1'b1);
      if (pick(0, 2) == 0) idle();
    end
    finish_test("overflow and flush");

    for (int i = 0; i < 100; i++) begin
      send_raw();
      if (pick(0, 2) == 0) idle();
    end
    finish_test("copy and logic ops");

    // back to back, no idle cycles between strobes
    for (int i = 0; i < 32; i++) begin
      if (pick(0, 3) == 0) send_raw();
      else send_arith(1, 480, 12, pick(0, 1), pick(0, 1));
    end
    finish_test("burst");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/fpadd_checker.sv
`timescale 1ns/1ns
`default_nettype none

module fpadd_checker (
  input wire clk,
  input wire rst,
  input wire in_valid,
  input wire fpadd_ctrl_pkg::fpadd_req_t req,
  input wire out_valid,
  input wire fp_word_pkg::fp_word_t res,
  input wire fpadd_ctrl_pkg::fpadd_flags_t flags,
  output int checks,
  output int errors,
  output int pending
);

  // expected {invalid, overflow, inexact, word} per request, plus its strobe cycle
  logic [35:0] exp_q[$];
  int tag_q[$];
  logic [35:0] want;
  int tag;
  int cyc;
  int pushed;
  int popped;

  assign pending = pushed - popped;

  function automatic logic [32:0] pack_word(input logic s, input logic [8:0] e,
                                            input logic [22:0] f);
    return {e[8], s, e[7:0], f};
  endfunction

  function automatic logic [35:0] expect_result(input logic [32:0] a, input logic [32:0] b,
                                                input logic [2:0] op, input logic [1:0] rm);
    logic [8:0] ea;
    logic [8:0] eb;
    logic [8:0] e_small;
    logic sa;
    logic sb;
    logic s_res;
    logic [23:0] m_big;
    logic [23:0] m_small;
    logic [63:0] full;
    logic [63:0] aligned;
    logic [63:0] sum;
    logic [24:0] man;
    logic guard;
    logic rest;
    logic inc;
    logic [32:0] nan_word;
    int e;
    int d;
    nan_word = pack_word(1'b1, 9'h1ff, 23'h400001);
    ea = {a[32], a[30:23]};
    eb = {b[32], b[30:23]};
    sa = a[31] ^ (op == 3'd2);
    sb = b[31] ^ (op == 3'd1);
    case (op)
      3'd3: return {3'b000, a};
      3'd4: return {3'b000, a & b};
      3'd5: return {3'b000, a | b};
      3'd6: return {3'b000, a ^ b};
      3'd7: return {3'b000, a & ~b};
      default: ;
    endcase
    if (ea == 9'h1ff || eb == 9'h1ff) return {3'b000, nan_word};
    if (ea == 9'h1fe && eb == 9'h1fe && sa != sb) return {3'b100, nan_word};
    if (ea == 9'h1fe) return {3'b000, pack_word(sa, 9'h1fe, 23'h0)};
    if (eb == 9'h1fe) return {3'b000, pack_word(sb, 9'h1fe, 23'h0)};
    if (ea == 9'h0 && eb == 9'h0) return {3'b000, pack_word(sa & sb, 9'h0, 23'h0)};
    if (eb == 9'h0) return {3'b000, a[32], sa, a[30:0]};
    if (ea == 9'h0) return {3'b000, b[32], sb, b[30:0]};

    // larger magnitude sets the sign
    if (ea > eb || (ea == eb && a[22:0] >= b[22:0])) begin
      e = ea;
      m_big = {1'b1, a[22:0]};
      s_res = sa;
      e_small = eb;
      m_small = {1'b1, b[22:0]};
    end else begin
      e = eb;
      m_big = {1'b1, b[22:0]};
      s_res = sb;
      e_small = ea;
      m_small = {1'b1, a[22:0]};
    end
    d = e - e_small;
    full = {37'b0, m_small, 3'b000};
    if (d >= 27) begin
      aligned = 64'd1;
    end else begin
      aligned = full >> d;
      aligned[0] = aligned[0] | ((full & ((64'd1 << d) - 64'd1)) != 64'd0);
    end
    if (sa != sb) sum = {37'b0, m_big, 3'b000} - aligned;
    else sum = {37'b0, m_big, 3'b000} + aligned;

    if (sum == 64'd0) return {3'b000, pack_word(rm == 2'd3, 9'h0, 23'h0)};
    if (sum[27]) begin
      sum = (sum >> 1) | sum[0];
      e = e + 1;
    end
    while (!sum[26]) begin
      sum = sum << 1;
      e = e - 1;
    end

    man = {1'b0, sum[26:3]};
    guard = sum[2];
    rest = sum[1:0] != 2'b00;
    case (rm)
      2'd1: inc = guard & (rest | man[0]);
      2'd2: inc = (guard | rest) & ~s_res;
      2'd3: inc = (guard | rest) & s_res;
      default: inc = 1'b0;
    endcase
    man = man + inc;
    if (man[24]) begin
      man = man >> 1;
      e = e + 1;
    end
    if (e > 509) return {3'b011, pack_word(s_res, 9'h1fe, 23'h0)};
    if (e <= 0) return {3'b001, pack_word(s_res, 9'h0, 23'h0)};
    return {2'b00, guard | rest, pack_word(s_res, e[8:0], man[22:0])};
  endfunction

  initial begin
    checks = 0;
    errors = 0;
    cyc = 0;
    pushed = 0;
    popped = 0;
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!rst && in_valid === 1'b1) begin
      exp_q.push_back(expect_result(req.a.raw, req.b.raw, req.op, req.rmode));
      tag_q.push_back(cyc);
      pushed = pushed + 1;
    end
  end

  // outputs settle after the rising edge, so look at them on the falling one
  always @(negedge clk) begin
    if (!rst && out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("out_valid was high with no request outstanding");
        errors = errors + 1;
      end else begin
        want = exp_q.pop_front();
        tag = tag_q.pop_front();
        popped = popped + 1;
        checks = checks + 1;
        // the result is taken at the next rising edge
        if (cyc + 1 - tag != 2) begin
          $display("result arrived %0d cycles after its strobe instead of 2", cyc + 1 - tag);
          errors = errors + 1;
        end
        if (res.raw !== want[32:0]) begin
          $display("ERR res expected %h got %h", want[32:0], res.raw);
          errors = errors + 1;
        end
        if (flags !== want[35:33]) begin
          $display("ERR flags expected %h got %h", want[35:33], flags);
          errors = errors + 1;
        end
      end
    end else if (!rst && out_valid !== 1'b0) begin
      $display("out_valid is unknown after reset");
      errors = errors + 1;
    end
  end

endmodule

`default_nettype wire

// File: bench/fpadd_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module fpadd_clkgen #(
  parameter int period = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: source/fpadd_top.sv
`timescale 1ns/1ns
`default_nettype none

module fpadd_top #(
  parameter int sticky_w = 3
) (
  input wire clk,
  input wire rst,
  input wire in_valid,
  input wire fpadd_ctrl_pkg::fpadd_req_t req,
  output logic out_valid,
  output fp_word_pkg::fp_word_t res,
  output fpadd_ctrl_pkg::fpadd_flags_t flags
);

  fpadd_ctrl_pkg::align_stage_t stage;
  logic stage_valid;
  logic [fp_word_pkg::man_w+sticky_w-1:0] norm_man;
  logic signed [9:0] norm_exp;
  logic spec_hit;
  fp_word_pkg::fp_word_t spec_res;
  logic spec_invalid;

  fpadd_special special_i (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .req(req),
    .spec_hit(spec_hit),
    .spec_res(spec_res),
    .spec_invalid(spec_invalid)
  );

  fpadd_align #(.sticky_w(sticky_w)) align_i (
    .clk(clk),
    .rst(rst),
    .in_valid(in_valid),
    .req(req),
    .stage(stage),
    .stage_valid(stage_valid)
  );

  fpadd_renorm #(.sticky_w(sticky_w)) renorm_i (
    .stage(stage),
    .norm_man(norm_man),
    .norm_exp(norm_exp)
  );

  fpadd_round #(.sticky_w(sticky_w)) round_i (
    .clk(clk),
    .rst(rst),
    .stage_valid(stage_valid),
    .stage(stage),
    .norm_man(norm_man),
    .norm_exp(norm_exp),
    .spec_hit(spec_hit),
    .spec_res(spec_res),
    .spec_invalid(spec_invalid),
    .out_valid(out_valid),
    .res(res),
    .flags(flags)
  );

endmodule

`default_nettype wire

// File: source/fpadd_round.sv
`timescale 1ns/1ns
`default_nettype none

module fpadd_round #(
  parameter int sticky_w = 3
) (
  input wire clk,
  input wire rst,
  input wire stage_valid,
  input wire fpadd_ctrl_pkg::align_stage_t stage,
  input wire [fp_word_pkg::man_w+sticky_w-1:0] norm_man,
  input wire signed [9:0] norm_exp,
  input wire spec_hit,
  input wire fp_word_pkg::fp_word_t spec_res,
  input wire spec_invalid,
  output logic out_valid,
  output fp_word_pkg::fp_word_t res,
  output fpadd_ctrl_pkg::fpadd_flags_t flags
);

  localparam int mw = fp_word_pkg::man_w + sticky_w;

  logic [fp_word_pkg::man_w-1:0] man;
  logic guard;
  logic rest;
  logic inc;
  logic [fp_word_pkg::man_w:0] rounded;
  logic signed [9:0] exp_r;
  fp_word_pkg::fp_word_t res_d;
  fpadd_ctrl_pkg::fpadd_flags_t flags_d;

  always_comb begin
    man = norm_man[mw-1:sticky_w];
    guard = norm_man[sticky_w-1];
    rest = |norm_man[sticky_w-2:0];

    case (stage.rmode)
      fpadd_ctrl_pkg::rnd_even: inc = guard & (rest | man[0]);
      fpadd_ctrl_pkg::rnd_plus: inc = (guard | rest) & ~stage.res_sign;
      fpadd_ctrl_pkg::rnd_minus: inc = (guard | rest) & stage.res_sign;
      default: inc = 1'b0;
    endcase

    rounded = {1'b0, man} + {{fp_word_pkg::man_w{1'b0}}, inc};
    exp_r = norm_exp;
    if (rounded[fp_word_pkg::man_w]) begin
      rounded = rounded >> 1;
      exp_r = norm_exp + 10'sd1;
    end

    res_d = '0;
    flags_d = '0;
    if (spec_hit) begin
      res_d = spec_res;
      flags_d.invalid = spec_invalid;
    end else if (norm_man == '0) begin
      // exact cancellation
      res_d.f.sign = (stage.rmode == fpadd_ctrl_pkg::rnd_minus);
    end else if (exp_r > $signed({1'b0, fp_word_pkg::exp_max_finite})) begin
      {res_d.f.exp_hi, res_d.f.exp_lo} = fp_word_pkg::exp_inf;
      res_d.f.sign = stage.res_sign;
      flags_d.overflow = 1'b1;
      flags_d.inexact = 1'b1;
    end else if (exp_r <= 10'sd0) begin
      // flush to signed zero
      res_d.f.sign = stage.res_sign;
      flags_d.inexact = 1'b1;
    end else begin
      {res_d.f.exp_hi, res_d.f.exp_lo} = exp_r[8:0];
      res_d.f.sign = stage.res_sign;
      res_d.f.frac = rounded[fp_word_pkg::frac_w-1:0];
      flags_d.inexact = guard | rest;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      res <= '0;
      flags <= '0;
    end else begin
      out_valid <= stage_valid;
      if (stage_valid) begin
        res <= res_d;
        flags <= flags_d;
      end
    end
  end

  a_valid_follows: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(stage_valid));

endmodule

`default_nettype wire

// File: source/fpadd_renorm.sv
`timescale 1ns/1ns
`default_nettype none

module fpadd_renorm #(
  parameter int sticky_w = 3
) (
  input wire fpadd_ctrl_pkg::align_stage_t stage,
  output logic [fp_word_pkg::man_w+sticky_w-1:0] norm_man,
  output logic signed [9:0] norm_exp
);

  localparam int mw = fp_word_pkg::man_w + sticky_w;

  logic [mw-1:0] big_ext;
  logic [mw:0] sum;
  logic [9:0] lz;

  always_comb begin
    big_ext = {stage.big_man, {sticky_w{1'b0}}};

    // big is never smaller, so the difference stays positive
    if (stage.subtract) begin
      sum = {1'b0, big_ext} - {1'b0, stage.small_man};
    end else begin
      sum = {1'b0, big_ext} + {1'b0, stage.small_man};
    end

    // highest set bit wins
    lz = 10'(mw);
    for (int i = 0; i < mw; i++) begin
      if (sum[i]) begin
        lz = 10'(mw - 1 - i);
      end
    end

    if (sum[mw]) begin
      // carry out, dropped bit folds into sticky
      norm_man = {sum[mw:2], sum[1] | sum[0]};
      norm_exp = $signed({1'b0, stage.big_exp}) + 10'sd1;
    end else begin
      norm_man = sum[mw-1:0] << lz;
      norm_exp = $signed({1'b0, stage.big_exp}) - $signed(lz);
    end
  end

endmodule

`default_nettype wire

// File: source/fpadd_align.sv
`timescale 1ns/1ns
`default_nettype none

module fpadd_align #(
  parameter int sticky_w = 3
) (
  input wire clk,
  input wire rst,
  input wire in_valid,
  input wire fpadd_ctrl_pkg::fpadd_req_t req,
  output fpadd_ctrl_pkg::align_stage_t stage,
  output logic stage_valid
);

  localparam int mw = fp_word_pkg::man_w + sticky_w;

  logic [8:0] ea;
  logic [8:0] eb;
  logic [8:0] small_exp;
  logic [8:0] diff;
  logic sa;
  logic sb;
  logic a_big;
  logic [fp_word_pkg::man_w-1:0] small_raw;
  logic [2*mw-1:0] shifted;
  fpadd_ctrl_pkg::align_stage_t stage_d;

  always_comb begin
    ea = {req.a.f.exp_hi, req.a.f.exp_lo};
    eb = {req.b.f.exp_hi, req.b.f.exp_lo};
    sa = req.a.f.sign ^ (req.op == fpadd_ctrl_pkg::op_rsub);
    sb = req.b.f.sign ^ (req.op == fpadd_ctrl_pkg::op_sub);

    // fractions break an exponent tie
    a_big = (ea > eb) || ((ea == eb) && (req.a.f.frac >= req.b.f.frac));

    if (a_big) begin
      stage_d.big_man = {1'b1, req.a.f.frac};
      stage_d.big_exp = ea;
      stage_d.res_sign = sa;
      small_raw = {1'b1, req.b.f.frac};
      small_exp = eb;
    end else begin
      stage_d.big_man = {1'b1, req.b.f.frac};
      stage_d.big_exp = eb;
      stage_d.res_sign = sb;
      small_raw = {1'b1, req.a.f.frac};
      small_exp = ea;
    end

    diff = stage_d.big_exp - small_exp;

    // low half collects everything shifted past the sticky position
    shifted = {small_raw, {sticky_w{1'b0}}, {mw{1'b0}}} >> diff;
    stage_d.small_man = {shifted[2*mw-1:mw+1], shifted[mw] | (|shifted[mw-1:0])};

    // far below the big operand only sticky is left
    if (diff >= 9'(mw)) begin
      stage_d.small_man = {{(mw-1){1'b0}}, 1'b1};
    end

    stage_d.subtract = sa ^ sb;
    stage_d.rmode = req.rmode;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      stage <= stage_d;
    end
  end

  a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(stage_valid));

endmodule

`default_nettype wire

// File: source/fpadd_special.sv
`timescale 1ns/1ns
`default_nettype none

module fpadd_special (
  input wire clk,
  input wire rst,
  input wire in_valid,
  input wire fpadd_ctrl_pkg::fpadd_req_t req,
  output logic spec_hit,
  output fp_word_pkg::fp_word_t spec_res,
  output logic spec_invalid
);

  logic [8:0] ea;
  logic [8:0] eb;
  logic sa;
  logic sb;
  logic hit_d;
  logic inv_d;
  fp_word_pkg::fp_word_t res_d;

  always_comb begin
    ea = {req.a.f.exp_hi, req.a.f.exp_lo};
    eb = {req.b.f.exp_hi, req.b.f.exp_lo};
    sa = req.a.f.sign ^ (req.op == fpadd_ctrl_pkg::op_rsub);
    sb = req.b.f.sign ^ (req.op == fpadd_ctrl_pkg::op_sub);
    hit_d = 1'b1;
    inv_d = 1'b0;
    res_d = '0;
    case (req.op)
      fpadd_ctrl_pkg::op_and: res_d.raw = req.a.raw & req.b.raw;
      fpadd_ctrl_pkg::op_or: res_d.raw = req.a.raw | req.b.raw;
      fpadd_ctrl_pkg::op_xor: res_d.raw = req.a.raw ^ req.b.raw;
      fpadd_ctrl_pkg::op_andn: res_d.raw = req.a.raw & ~req.b.raw;
      fpadd_ctrl_pkg::op_copy_a: res_d = req.a;
      default: begin
        if (ea == fp_word_pkg::exp_nan || eb == fp_word_pkg::exp_nan) begin
          res_d.raw = fp_word_pkg::canonical_nan;
        end else if (ea == fp_word_pkg::exp_inf && eb == fp_word_pkg::exp_inf && sa != sb) begin
          res_d.raw = fp_word_pkg::canonical_nan;
          inv_d = 1'b1;
        end else if (ea == fp_word_pkg::exp_inf) begin
          {res_d.f.exp_hi, res_d.f.exp_lo} = fp_word_pkg::exp_inf;
          res_d.f.sign = sa;
        end else if (eb == fp_word_pkg::exp_inf) begin
          {res_d.f.exp_hi, res_d.f.exp_lo} = fp_word_pkg::exp_inf;
          res_d.f.sign = sb;
        end else if (ea == fp_word_pkg::exp_zero && eb == fp_word_pkg::exp_zero) begin
          // -0 only when both operands are negative zeros
          res_d.f.sign = sa & sb;
        end else if (eb == fp_word_pkg::exp_zero) begin
          res_d = req.a;
          res_d.f.sign = sa;
        end else if (ea == fp_word_pkg::exp_zero) begin
          res_d = req.b;
          res_d.f.sign = sb;
        end else begin
          hit_d = 1'b0;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      spec_hit <= 1'b0;
      spec_invalid <= 1'b0;
    end else begin
      spec_hit <= in_valid & hit_d;
      spec_invalid <= in_valid & inv_d;
    end
  end

  always_ff @(posedge clk) begin
    spec_res <= res_d;
  end

  // invalid only ever comes from a rule result
  a_inv_has_hit: assert property (@(posedge clk) disable iff (rst) spec_invalid |-> spec_hit);

endmodule

`default_nettype wire

// File: source/fpadd_ctrl_pkg.sv
`default_nettype none

package fpadd_ctrl_pkg;

  typedef enum logic [2:0] {
    op_add    = 3'd0,
    op_sub    = 3'd1,
    // b minus a
    op_rsub   = 3'd2,
    op_copy_a = 3'd3,
    op_and    = 3'd4,
    op_or     = 3'd5,
    op_xor    = 3'd6,
    op_andn   = 3'd7
  } fpadd_op_e;

  typedef enum logic [1:0] {
    rnd_trunc = 2'd0,
    rnd_even  = 2'd1,
    rnd_plus  = 2'd2,
    rnd_minus = 2'd3
  } round_mode_e;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic inexact;
  } fpadd_flags_t;

  typedef struct packed {
    fp_word_pkg::fp_word_t a;
    fp_word_pkg::fp_word_t b;
    fpadd_op_e op;
    round_mode_e rmode;
  } fpadd_req_t;

  // small_man carries guard, round and sticky below the aligned mantissa
  typedef struct packed {
    logic [23:0] big_man;
    logic [26:0] small_man;
    logic [8:0] big_exp;
    logic res_sign;
    logic subtract;
    round_mode_e rmode;
  } align_stage_t;

endpackage

`default_nettype wire

// File: source/fp_word_pkg.sv
`default_nettype none

package fp_word_pkg;

  localparam int word_w = 33;
  localparam int exp_w = 9;
  localparam int frac_w = 23;
  // fraction plus hidden one
  localparam int man_w = 24;

  // top exponent bit sits above the sign
  typedef struct packed {
    logic exp_hi;
    logic sign;
    logic [7:0] exp_lo;
    logic [frac_w-1:0] frac;
  } fp_fields_t;

  // fields for arithmetic, raw bits for logic ops and copy
  typedef union packed {
    fp_fields_t f;
    logic [word_w-1:0] raw;
  } fp_word_t;

  localparam logic [exp_w-1:0] exp_zero = 9'h000;
  localparam logic [exp_w-1:0] exp_inf = 9'h1fe;
  localparam logic [exp_w-1:0] exp_nan = 9'h1ff;
  localparam logic [exp_w-1:0] exp_max_finite = 9'h1fd;

  // single quiet nan for every invalid or nan result
  localparam logic [word_w-1:0] canonical_nan = {
    1'b1,
    1'b1,
    8'hff,
    23'h400001
  };

endpackage

`default_nettype wire
